// File: design/baudRateGenerator.sv
module baudRateGenerator import uartPkg::*; #(
   parameter baudAcc_t inc       = incBaud,
   parameter bit       halfPhase = 1'b1     // 0: hold at zero, first tick after a whole bit
) (
   input  logic CLK50MHZ,
   input  logic RST,
   input  logic en,
   output logic tick
);

   baudAcc_t         acc;
   logic [accWidth:0] sum;   // one extra bit for the carry

   assign sum = {1'b0, acc} + {1'b0, inc};

   always_ff @(posedge CLK50MHZ) begin
      if (RST || !en) begin
         acc  <= halfPhase ? accHalf : '0;
         tick <= 1'b0;
      end else begin
         acc  <= sum[accWidth-1:0];
         tick <= sum[accWidth];   // carry out
      end
   end

endmodule

// File: design/frameShifter.sv
module frameShifter import uartPkg::*; (
   input  logic   CLK50MHZ,
   input  logic   RST,
   input  logic   load,
   input  frame_t frameIn,
   input  logic   tick,
   input  logic   serialIn,
   output frame_t frame,
   output logic   serialOut,
   output logic   done
);

   bitCnt_t bitCnt;

   // shifts toward index 0, new bit enters at the top
   always_ff @(posedge CLK50MHZ) begin
      if (load) begin
         frame <= frameIn;
      end else if (tick) begin
         frame <= {serialIn, frame[frameBits-1:1]};
      end
   end

   assign serialOut = frame[0];

   always_ff @(posedge CLK50MHZ) begin
      if (RST) begin
         bitCnt <= '0;
         done   <= 1'b0;
      end else begin
         done <= 1'b0;
         if (load) begin
            bitCnt <= '0;
         end else if (tick && bitCnt != bitCnt_t'(frameBits)) begin
            bitCnt <= bitCnt + 1'b1;
            // last shift of the frame
            if (bitCnt == bitCnt_t'(frameBits - 1))
               done <= 1'b1;
         end
      end
   end

endmodule

// File: design/rs232Rx.sv
module rs232Rx import uartPkg::*; (
   input  logic  CLK50MHZ,
   input  logic  RST,
   input  logic  rxD,
   output byte_t rxData,
   output logic  rxDataReady
);

   rxState_t   state;

   logic       rxMeta;
   logic       rxSync;
   logic [2:0] rx3;      // last three samples
   logic       vote;

   logic       rxEn;
   logic       tick;
   logic       tick3;
   logic       load;
   logic       done;
   frame_t     rxFrame;

   assign rxEn = (state == receiving);
   assign load = (state == startRx);

   // samples at 1/6, 1/2 and 5/6 of each bit
   baudRateGenerator #(
      .inc       (incBaud3),
      .halfPhase (1'b1)
   ) rxBaud3 (
      .CLK50MHZ (CLK50MHZ),
      .RST      (RST),
      .en       (rxEn),
      .tick     (tick3)
   );

   // bit tick falls on the bit boundary, after all three samples are in
   baudRateGenerator #(
      .inc       (incBaud),
      .halfPhase (1'b0)
   ) rxBaud (
      .CLK50MHZ (CLK50MHZ),
      .RST      (RST),
      .en       (rxEn),
      .tick     (tick)
   );

   always_ff @(posedge CLK50MHZ) begin
      if (RST) begin
         rxMeta <= 1'b1;   // idle line
         rxSync <= 1'b1;
      end else begin
         rxMeta <= rxD;
         rxSync <= rxMeta;
      end
   end

   always_ff @(posedge CLK50MHZ) begin
      if (tick3)
         rx3 <= {rx3[1:0], rxSync};
   end

   // two out of three
   assign vote = (rx3[0] & rx3[1]) | (rx3[0] & rx3[2]) | (rx3[1] & rx3[2]);

   frameShifter rxShift (
      .CLK50MHZ  (CLK50MHZ),
      .RST       (RST),
      .load      (load),
      .frameIn   ('0),
      .tick      (tick),
      .serialIn  (vote),
      .frame     (rxFrame),
      .serialOut (),
      .done      (done)
   );

   assign rxData = rxFrame[8:1];   // drop start and stop

   always_ff @(posedge CLK50MHZ) begin
      if (RST) begin
         state <= waitStart;
      end else begin
         case (state)
            waitStart: if (!rxSync) state <= startRx;
            startRx:   state <= receiving;
            receiving: if (done) state <= received;
            received:  state <= waitStart;
            default:   state <= waitStart;
         endcase
      end
   end

   assign rxDataReady = (state == received);

endmodule

// File: design/rs232Top.sv
module rs232Top import uartPkg::*; (
   input  logic  CLK50MHZ,
   input  logic  RST,
   input  logic  rxD,        // board pins
   output logic  txD,
   output byte_t rxData,     // user side
   output logic  rxDataReady,
   input  byte_t txData,
   input  logic  txStart,
   output logic  txBusy
);

   rs232Rx rs232Rx_inst (
      .CLK50MHZ    (CLK50MHZ),
      .RST         (RST),
      .rxD         (rxD),
      .rxData      (rxData),
      .rxDataReady (rxDataReady)
   );

   rs232Tx rs232Tx_inst (
      .CLK50MHZ (CLK50MHZ),
      .RST      (RST),
      .txData   (txData),
      .txStart  (txStart),
      .txD      (txD),
      .txBusy   (txBusy)
   );

endmodule

// File: design/rs232Tx.sv
module rs232Tx import uartPkg::*; (
   input  logic  CLK50MHZ,
   input  logic  RST,
   input  byte_t txData,
   input  logic  txStart,
   output logic  txD,
   output logic  txBusy
);

   txState_t state;

   logic     txEn;
   logic     tick;
   logic     load;
   logic     serialOut;
   logic     done;
   frame_t   txFrame;

   assign txEn    = (state == sending);
   assign load    = (state == idle) && txStart;   // strobe ignored while busy
   assign txFrame = {stopBit, txData, startBit};

   // starts from zero so the start bit is a whole bit long
   baudRateGenerator #(
      .inc       (incBaud),
      .halfPhase (1'b0)
   ) txBaud (
      .CLK50MHZ (CLK50MHZ),
      .RST      (RST),
      .en       (txEn),
      .tick     (tick)
   );

   frameShifter txShift (
      .CLK50MHZ  (CLK50MHZ),
      .RST       (RST),
      .load      (load),
      .frameIn   (txFrame),
      .tick      (tick),
      .serialIn  (stopBit),   // fill with idle level
      .frame     (),
      .serialOut (serialOut),
      .done      (done)
   );

   always_ff @(posedge CLK50MHZ) begin
      if (RST) begin
         state <= idle;
      end else begin
         case (state)
            idle:    if (txStart) state <= sending;
            sending: if (done) state <= idle;
            default: state <= idle;
         endcase
      end
   end

   always_ff @(posedge CLK50MHZ) begin
      if (RST)
         txD <= stopBit;
      else
         txD <= txEn ? serialOut : stopBit;
   end

   assign txBusy = txEn;

endmodule

// File: design/uartPkg.sv
package uartPkg;

   // board clock and line rate
   localparam logic [31:0] clkFreq  = 32'd50_000_000;
   localparam logic [31:0] baudRate = 32'd115_200;

   // accumulator is log2(baudRate) bits wide, 17 here
   localparam int accWidth = $clog2(baudRate);

   typedef logic [accWidth-1:0] baudAcc_t;

   // increments, rounded, scaled down to stay inside 32 bits
   localparam baudAcc_t incBaud =
      baudAcc_t'(((baudRate << (accWidth - 4)) + (clkFreq >> 5)) / (clkFreq >> 4));   // ~302
   localparam baudAcc_t incBaud3 =
      baudAcc_t'((((baudRate * 3) << (accWidth - 7)) + (clkFreq >> 8)) / (clkFreq >> 7)); // ~906

   localparam baudAcc_t accHalf = baudAcc_t'(1) << (accWidth - 1);   // mid-bit phase

   // frame: start, 8 data LSB first, stop
   localparam int frameBits = 10;
   localparam logic startBit = 1'b0;
   localparam logic stopBit  = 1'b1;   // also the idle line level

   typedef logic [7:0]                       byte_t;
   typedef logic [frameBits-1:0]             frame_t;   // [0] start, [9] stop
   typedef logic [$clog2(frameBits+1)-1:0]   bitCnt_t;

   typedef enum logic [1:0] {
      waitStart,
      startRx,
      receiving,
      received
   } rxState_t;

   typedef enum logic {
      idle,
      sending
   } txState_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# builds and runs the rs232Top testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f src.f --top-module rs232TopTb --Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if grep -qF '*** FAILED ***' "$logFile"; then
   echo "test failed, see $logFile"
   exit 1
fi

echo "test passed"
exit 0

// File: src.f
design/uartPkg.sv
design/baudRateGenerator.sv
design/frameShifter.sv
design/rs232Rx.sv
design/rs232Tx.sv
design/rs232Top.sv
tests/rs232Top_sva.sv
tests/rs232TopTb.sv

// File: tests/rs232TopTb.sv
module rs232TopTb import uartPkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int bitCycles = 434;   // 50 MHz / 115200
   localparam int glitchLen = 100;

   logic        CLK50MHZ;
   logic        RST;
   logic        rxD;
   logic        txD;
   byte_t       rxData;
   logic        rxDataReady;
   byte_t       txData;
   logic        txStart;
   logic        txBusy;
   logic        rxDrive;
   logic        loopback;
   int          errors = 0;
   int          timeouts = 0;
   int          checks = 0;
   int          readyCount = 0;
   byte_t       lastRx;
   logic [31:0] rngState = 32'he5e60c78;

   assign rxD = loopback ? txD : rxDrive;

   rs232Top rs232Top_inst (
      .CLK50MHZ    (CLK50MHZ),
      .RST         (RST),
      .rxD         (rxD),
      .txD         (txD),
      .rxData      (rxData),
      .rxDataReady (rxDataReady),
      .txData      (txData),
      .txStart     (txStart),
      .txBusy      (txBusy)
   );

   initial begin
      CLK50MHZ = 1'b0;
      forever #10 CLK50MHZ = ~CLK50MHZ;
   end

   always @(posedge CLK50MHZ) begin
      if (rxDataReady) begin
         readyCount <= readyCount + 1;
         lastRx     <= rxData;   // only valid in the ready cycle
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] nextRandom();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   task automatic waitCycles(input int n);
      repeat (n) begin
         @(posedge CLK50MHZ);
         #2;
      end
   endtask

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic reportTimeout(input string what);
      timeouts++;
      $display("timeout at %0t while waiting for %s", $time, what);
   endtask

   task automatic pulseTxStart(input byte_t b);
      txData  = b;
      txStart = 1'b1;
      waitCycles(1);
      txStart = 1'b0;
   endtask

   // bit-banged frame on rxD, glitchBit is a frame index or -1
   task automatic sendRxByte(input byte_t b, input int glitchBit, input int glitchAt);
      frame_t bits;
      logic   level;
      int     k;
      int     c;
      bits = {1'b1, b, 1'b0};
      for (k = 0; k < 10; k++) begin
         for (c = 0; c < bitCycles; c++) begin
            level = bits[k];
            if (k == glitchBit && c >= glitchAt && c < glitchAt + glitchLen)
               level = ~level;
            rxDrive = level;
            waitCycles(1);
         end
      end
   endtask

   task automatic expectRxByte(input byte_t b, input int countBefore, input int budget);
      int n;
      n = 0;
      while (readyCount == countBefore && n < budget) begin
         waitCycles(1);
         n++;
      end
      if (readyCount == countBefore) begin
         reportTimeout("rxDataReady");
      end else begin
         waitCycles(20);   // a second pulse would show here
         checkValue("rxDataReady pulses", countBefore + 1, readyCount);
         checkValue("rxData", b, lastRx);
      end
   endtask

   task automatic waitTxIdle(input int budget);
      int n;
      n = 0;
      while (txBusy && n < budget) begin
         waitCycles(1);
         n++;
      end
      if (txBusy)
         reportTimeout("txBusy to fall");
   endtask

   // samples txD mid-bit, optionally fires a stray txStart after bit injectBit
   task automatic monitorTx(input byte_t b, input int injectBit);
      frame_t expFrame;
      int     k;
      int     n;
      logic   activity;
      expFrame = {1'b1, b, 1'b0};
      n = 0;
      while (txD !== 1'b0 && n < 10) begin
         waitCycles(1);
         n++;
      end
      if (txD !== 1'b0) begin
         reportTimeout("start bit on txD");
      end else begin
         waitCycles(bitCycles / 2);
         for (k = 0; k < 10; k++) begin
            checkValue("txD", expFrame[k], txD);
            checkValue("txBusy", 1, txBusy);
            if (k == injectBit) begin
               pulseTxStart(~b);
               waitCycles(bitCycles - 1);
            end else if (k < 9) begin
               waitCycles(bitCycles);
            end
         end
         waitTxIdle(bitCycles);
         activity = 1'b0;
         for (n = 0; n < 2 * bitCycles; n++) begin
            if (txBusy || !txD)
               activity = 1'b1;
            waitCycles(1);
         end
         checkValue("txBusy after frame", 0, activity);
      end
   endtask

   initial begin
      logic [31:0] r;
      byte_t       b;
      int          i;
      int          idx;
      int          countBefore;
      RST      = 1'b1;
      rxDrive  = 1'b1;
      loopback = 1'b0;
      txData   = '0;
      txStart  = 1'b0;
      repeat (10) @(posedge CLK50MHZ);
      #2;
      RST = 1'b0;
      waitCycles(2);
      checkValue("txD", 1, txD);
      checkValue("rxDataReady", 0, rxDataReady);
      checkValue("txBusy", 0, txBusy);

      for (i = 0; i < 20; i++) begin
         r = nextRandom();
         b = r[7:0];
         countBefore = readyCount;
         sendRxByte(b, -1, 0);
         expectRxByte(b, countBefore, bitCycles);
      end

      // even passes glitch a high bit low, odd passes a low bit high
      for (i = 0; i < 8; i++) begin
         r = nextRandom();
         b = r[7:0];
         idx = int'(r[10:8]);
         b[idx] = ~i[0];
         countBefore = readyCount;
         sendRxByte(b, idx + 1, 10 + int'(r[31:16] % (bitCycles - glitchLen - 20)));
         expectRxByte(b, countBefore, bitCycles);
      end

      for (i = 0; i < 4; i++) begin
         r = nextRandom();
         b = r[7:0];
         pulseTxStart(b);
         monitorTx(b, i[0] ? int'(r[10:8]) + 1 : -1);
      end

      loopback = 1'b1;
      for (i = 0; i < 10; i++) begin
         r = nextRandom();
         b = r[7:0];
         countBefore = readyCount;
         pulseTxStart(b);
         expectRxByte(b, countBefore, 12 * bitCycles);
         waitTxIdle(2 * bitCycles);
      end

      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: tests/rs232Top_sva.sv
module rs232TopSva (
   input logic CLK50MHZ,
   input logic RST,
   input logic rxDataReady,
   input logic txD,
   input logic txBusy,
   input logic txStart
);

   timeunit 1ns;
   timeprecision 1ps;

   // ready is a strobe, never a level
   readyOneCycle: assert property (
      @(posedge CLK50MHZ) disable iff (RST)
      rxDataReady |=> !rxDataReady
   ) else $error("rxDataReady stayed high for two cycles");

   idleLineHigh: assert property (
      @(posedge CLK50MHZ) disable iff (RST)
      !txBusy |-> txD
   ) else $error("txD low while the transmitter is idle");

   // busy only follows an accepted start strobe
   busyNeedsStart: assert property (
      @(posedge CLK50MHZ) disable iff (RST)
      $rose(txBusy) |-> $past(txStart)
   ) else $error("txBusy rose without a txStart in the previous cycle");

endmodule

bind rs232Top rs232TopSva rs232TopSva_inst (
   .CLK50MHZ    (CLK50MHZ),
   .RST         (RST),
   .rxDataReady (rxDataReady),
   .txD         (txD),
   .txBusy      (txBusy),
   .txStart     (txStart)
);
